// File: switch_bank_defs.svh
//////////////////////////////////////////////////
// Build-time constants for the switch bank
// SW_INDEX_W must be wide enough to number SW_COUNT
// switches, and SW_DEBOUNCE_W must hold the value
// SW_DEBOUNCE_CLKS without wrapping
//////////////////////////////////////////////////

`ifndef SWITCH_BANK_DEFS_SVH
`define SWITCH_BANK_DEFS_SVH

// Number of mechanical switches in the bank
`define SW_COUNT 4

// Bits needed to number one switch
`define SW_INDEX_W 2

// Consecutive differing cycles before a new level is taken
`define SW_DEBOUNCE_CLKS 16

// Width of the per-switch debounce counter
`define SW_DEBOUNCE_W 5

`endif

// File: switch_bank_pkg.sv
//////////////////////////////////////////////////
// Shared types for the switch bank
// Widths come from the `define header, so every
// user of these types sees the same sizes
//////////////////////////////////////////////////

`include "switch_bank_defs.svh"

package switch_bank_pkg;

  // One bit per switch, bit i belongs to switch i
  typedef logic [`SW_COUNT-1:0] sw_vec_t;

  // Number of a single switch
  typedef logic [`SW_INDEX_W-1:0] sw_index_t;

  // Count of consecutive cycles the input has differed from the output
  typedef logic [`SW_DEBOUNCE_W-1:0] debounce_cnt_t;

  // Handshake state of the event queue
  // idle          no request out, free to pick the next pending switch
  // req_high      request is out and the payload is frozen
  // wait_ack_low  request dropped, host must release ack before the next one
  typedef enum logic [1:0] {
    idle,
    req_high,
    wait_ack_low
  } evq_state_t;

endpackage

// File: io_synchronizer.sv
//////////////////////////////////////////////////
// Two-flop synchronizer for one asynchronous pin
// The output follows the input two clk edges later
// and reads zero while in reset
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module io_synchronizer (
  input  wire  clk,
  input  wire  rst_n,
  input  logic bit_ingress,
  output logic bit_egress
);

  // First stage may go metastable, it is never used outside this module
  logic meta_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta_q     <= 1'b0;
      bit_egress <= 1'b0;
    end else begin
      // The second stage gives the first a full cycle to settle
      meta_q     <= bit_ingress;
      bit_egress <= meta_q;
    end
  end

endmodule

`default_nettype wire

// File: switch_core.sv
//////////////////////////////////////////////////
// Synchronizer and counting debouncer for one switch
// A stable pin change reaches switch_out after
// 2 + debounce_clks + 1 cycles. debounce_clks must
// fit in debounce_cnt_t. The output resets to zero
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none
`include "switch_bank_defs.svh"

module switch_core #(
  parameter int debounce_clks = `SW_DEBOUNCE_CLKS
) (
  input  wire  clk,
  input  wire  rst_n,
  input  logic switch_in_pin,
  output logic switch_out
);

  // Pin after the two-flop synchronizer
  logic                          sync_level;

  // Cycles that sync_level has differed from switch_out
  switch_bank_pkg::debounce_cnt_t debounce_cnt;

  // Terminal count in the counter's own width
  switch_bank_pkg::debounce_cnt_t debounce_max;

  // Input and output disagree, so a change may be on its way
  logic                          level_differs;

  assign debounce_max  = switch_bank_pkg::debounce_cnt_t'(debounce_clks);
  assign level_differs = (sync_level != switch_out);

  //////////////////////////////////////////////////
  // Synchronizer
  //////////////////////////////////////////////////

  io_synchronizer sync_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .bit_ingress (switch_in_pin),
    .bit_egress  (sync_level)
  );

  //////////////////////////////////////////////////
  // Debouncer
  //////////////////////////////////////////////////

  // The counter only runs while the synchronized pin and the debounced
  // level disagree. Any cycle of agreement clears it, so a bounce or a
  // glitch that returns before the terminal count leaves no trace
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      switch_out   <= 1'b0;
      debounce_cnt <= '0;
    end else begin
      if (level_differs) begin
        if (debounce_cnt == debounce_max) begin
          // Held long enough, take the new level and start over
          switch_out   <= sync_level;
          debounce_cnt <= '0;
        end else begin
          debounce_cnt <= debounce_cnt + 1'b1;
        end
      end else begin
        // Input went back to the current level
        debounce_cnt <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: switch_event_queue.sv
//////////////////////////////////////////////////
// Change detection and host reporting for the bank
// One event per pending switch, lowest index first,
// over a four-phase req/ack handshake. Repeated
// changes of a switch that is still pending merge
// into one event. No time stamp is kept
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none
`include "switch_bank_defs.svh"

module switch_event_queue (
  input  wire                        clk,
  input  wire                        rst_n,
  input  switch_bank_pkg::sw_vec_t   levels,
  output logic                       event_req,
  output switch_bank_pkg::sw_index_t event_index,
  output logic                       event_level,
  input  logic                       event_ack
);

  // Debounced levels of the previous cycle
  switch_bank_pkg::sw_vec_t    levels_q;

  // Switches whose level changed and which have not been reported yet
  switch_bank_pkg::sw_vec_t    pending;

  // Switches that changed in the current cycle
  switch_bank_pkg::sw_vec_t    changed;

  // Pending bit to drop when the host accepts the current event
  switch_bank_pkg::sw_vec_t    clear_mask;

  // Lowest pending switch and whether there is any at all
  switch_bank_pkg::sw_index_t  sel_index;
  logic                        any_pending;

  // Handshake state
  switch_bank_pkg::evq_state_t state;

  //////////////////////////////////////////////////
  // Change detection
  //////////////////////////////////////////////////

  assign changed = levels ^ levels_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      levels_q <= '0;
    end else begin
      levels_q <= levels;
    end
  end

  //////////////////////////////////////////////////
  // Pending flags
  //////////////////////////////////////////////////

  // The host accepts an event when ack is seen high in req_high
  always_comb begin
    clear_mask = '0;
    if (state == switch_bank_pkg::req_high && event_ack) begin
      clear_mask[event_index] = 1'b1;
    end
  end

  // New changes are OR-ed in after the clear, so a switch that changes
  // again in the very cycle of its ack stays pending for a later event
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clear_mask) | changed;
    end
  end

  //////////////////////////////////////////////////
  // Lowest-index selection
  //////////////////////////////////////////////////

  // Scan from the top down so the lowest set bit is written last and wins
  always_comb begin
    sel_index = '0;
    for (int i = `SW_COUNT - 1; i >= 0; i--) begin
      if (pending[i]) begin
        sel_index = switch_bank_pkg::sw_index_t'(i);
      end
    end
  end

  assign any_pending = |pending;

  //////////////////////////////////////////////////
  // Host handshake
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= switch_bank_pkg::idle;
      event_req   <= 1'b0;
      event_index <= '0;
      event_level <= 1'b0;
    end else begin
      case (state)
        switch_bank_pkg::idle: begin
          // A new request only goes out while the host holds ack low
          if (any_pending && !event_ack) begin
            event_index <= sel_index;
            event_level <= levels[sel_index];
            event_req   <= 1'b1;
            state       <= switch_bank_pkg::req_high;
          end
        end
        switch_bank_pkg::req_high: begin
          // Payload stays frozen until the host acknowledges
          if (event_ack) begin
            event_req <= 1'b0;
            state     <= switch_bank_pkg::wait_ack_low;
          end
        end
        switch_bank_pkg::wait_ack_low: begin
          // Close the fourth phase before looking at the flags again
          if (!event_ack) begin
            state <= switch_bank_pkg::idle;
          end
        end
        default: begin
          event_req <= 1'b0;
          state     <= switch_bank_pkg::idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: switch_bank_top.sv
//////////////////////////////////////////////////
// Input block for SW_COUNT mechanical switches
// Every pin is synchronized and debounced on its
// own, then one queue reports level changes to a
// host. No interrupt and no register bus
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none
`include "switch_bank_defs.svh"

module switch_bank_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  switch_bank_pkg::sw_vec_t   switch_pins,
  output switch_bank_pkg::sw_vec_t   switch_levels,
  output logic                       event_req,
  output switch_bank_pkg::sw_index_t event_index,
  output logic                       event_level,
  input  logic                       event_ack
);

  // Debounced level of every switch
  switch_bank_pkg::sw_vec_t debounced;

  //////////////////////////////////////////////////
  // One core per pin
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `SW_COUNT; i++) begin : gen_core
    switch_core #(
      .debounce_clks (`SW_DEBOUNCE_CLKS)
    ) core_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .switch_in_pin (switch_pins[i]),
      .switch_out    (debounced[i])
    );
  end

  // The host can also read the levels directly
  assign switch_levels = debounced;

  //////////////////////////////////////////////////
  // Event reporting
  //////////////////////////////////////////////////

  switch_event_queue queue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .levels      (debounced),
    .event_req   (event_req),
    .event_index (event_index),
    .event_level (event_level),
    .event_ack   (event_ack)
  );

endmodule

`default_nettype wire

// File: switch_bank_tb.sv
//////////////////////////////////////////////////
// Testbench for switch_bank_top
// Pins change only by stable holds or by glitches
// shorter than the debounce length, and no pin
// moves while the host serves an event, so the
// reference model can predict every event
//////////////////////////////////////////////////

`timescale 1ns/100ps
`include "switch_bank_defs.svh"

module switch_bank_tb;

  // A held change must cross the synchronizer, the counter and the queue
  localparam int HOLD_CLKS      = `SW_DEBOUNCE_CLKS + 12;
  // Glitches are kept strictly shorter than this
  localparam int GLITCH_MAX     = `SW_DEBOUNCE_CLKS - 3;
  localparam int REQ_TIMEOUT    = 60;
  localparam int QUIET_CLKS     = 40;
  localparam int RANDOM_CHANGES = 200;

  logic                       clk;
  logic                       rst_n;
  switch_bank_pkg::sw_vec_t   pins;
  switch_bank_pkg::sw_vec_t   switch_levels;
  logic                       event_req;
  switch_bank_pkg::sw_index_t event_index;
  logic                       event_level;
  logic                       event_ack;

  logic [31:0] rng_state;

  // Reference model of the expected debounced levels and pending switches
  switch_bank_pkg::sw_vec_t exp_levels;
  switch_bank_pkg::sw_vec_t exp_pending;
  // The event the queue should have latched, if any
  logic                     inflight_valid;
  int                       inflight_index;
  logic                     inflight_level;

  int checks;
  int errors;
  int tests_run;
  int tests_failed;
  int test_start_errors;

  switch_bank_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .switch_pins   (pins),
    .switch_levels (switch_levels),
    .event_req     (event_req),
    .event_index   (event_index),
    .event_level   (event_level),
    .event_ack     (event_ack)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Steps the generator and returns a value from 0 to n-1
  function int random_below(input int unsigned n);
    rng_state = xorshift32(rng_state);
    return int'(rng_state % n);
  endfunction

  function automatic switch_bank_pkg::sw_vec_t one_hot(input int sw);
    switch_bank_pkg::sw_vec_t v;
    v     = '0;
    v[sw] = 1'b1;
    return v;
  endfunction

  // Returns -1 when no bit is set
  function automatic int lowest_set(input switch_bank_pkg::sw_vec_t v);
    int idx;
    idx = -1;
    for (int i = 0; i < `SW_COUNT; i++) begin
      if (v[i] && idx < 0) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  task automatic print_counts();
    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
  endtask

  // A host that never sees a request cannot go on with the sequence
  task automatic abort_run(input string msg);
    report_problem(msg);
    print_counts();
    $display("TEST FAIL");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // With no request out and ack low, the queue latches the lowest
  // pending switch together with its level at that moment
  task automatic update_inflight();
    int idx;
    if (!inflight_valid) begin
      idx = lowest_set(exp_pending);
      if (idx >= 0) begin
        inflight_valid = 1'b1;
        inflight_index = idx;
        inflight_level = exp_levels[idx];
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Pin and host drivers
  //////////////////////////////////////////////////

  // Toggles every pin in mask in the same cycle and holds it
  task automatic apply_changes(input switch_bank_pkg::sw_vec_t mask, input int hold);
    @(negedge clk);
    pins = pins ^ mask;
    repeat (hold) @(negedge clk);
    // A stable change is always taken, and it marks the switch pending
    exp_levels  = pins;
    exp_pending = exp_pending | mask;
    update_inflight();
    check_value("switch_levels", 32'(switch_levels), 32'(exp_levels));
  endtask

  task automatic glitch_pin(input int sw, input int width);
    @(negedge clk);
    pins[sw] = ~pins[sw];
    repeat (width) @(negedge clk);
    pins[sw] = ~pins[sw];
  endtask

  // Any request seen here is an extra event
  task automatic expect_quiet(input int cycles);
    int n;
    logic seen;
    seen = 1'b0;
    n    = 0;
    while (n < cycles && !seen) begin
      @(negedge clk);
      n++;
      if (event_req) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      report_problem("event_req rose although no event was pending");
    end
  endtask

  // Takes one event through all four phases and checks its payload
  task automatic serve_event(input int ack_delay);
    int waited;
    switch_bank_pkg::sw_index_t held_index;
    logic held_level;
    waited = 0;
    while (!event_req && waited < REQ_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!event_req) begin
      abort_run("timeout waiting for event_req to rise");
    end else begin
      held_index = event_index;
      held_level = event_level;
      if (inflight_valid) begin
        check_value("event_index", 32'(event_index), 32'(inflight_index));
        check_value("event_level", 32'(event_level), 32'(inflight_level));
      end else begin
        report_problem("event_req rose with no event expected");
      end
      // The payload must not move while the host takes its time
      repeat (ack_delay) begin
        @(negedge clk);
        check_value("event_req", 32'(event_req), 32'd1);
        check_value("event_index", 32'(event_index), 32'(held_index));
        check_value("event_level", 32'(event_level), 32'(held_level));
      end
      event_ack = 1'b1;
      waited    = 0;
      while (event_req && waited < REQ_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (event_req) begin
        report_problem("timeout waiting for event_req to fall after ack");
      end
      event_ack = 1'b0;
      if (inflight_valid) begin
        exp_pending[inflight_index] = 1'b0;
        inflight_valid              = 1'b0;
      end
      update_inflight();
    end
  endtask

  // Serves everything the model expects, then looks for strays
  task automatic drain_events();
    while (inflight_valid) begin
      serve_event(random_below(8));
    end
    expect_quiet(QUIET_CLKS);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int sw;
    int other;

    rst_n             = 1'b0;
    pins              = '0;
    event_ack         = 1'b0;
    rng_state         = 32'hf08a_3a35;
    exp_levels        = '0;
    exp_pending       = '0;
    inflight_valid    = 1'b0;
    inflight_index    = 0;
    inflight_level    = 1'b0;
    checks            = 0;
    errors            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    test_start_errors = 0;

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Everything must come out of reset cleared
    check_value("switch_levels", 32'(switch_levels), 32'd0);
    check_value("event_req", 32'(event_req), 32'd0);
    check_value("event_index", 32'(event_index), 32'd0);
    check_value("event_level", 32'(event_level), 32'd0);
    finish_test("reset_state");

    sw = random_below(`SW_COUNT);
    apply_changes(one_hot(sw), HOLD_CLKS);
    drain_events();
    finish_test("single_change");

    // None of these pulses is long enough to pass the debouncer
    repeat (12) begin
      glitch_pin(random_below(`SW_COUNT), random_below(GLITCH_MAX - 1) + 1);
      repeat (random_below(4)) @(negedge clk);
    end
    expect_quiet(HOLD_CLKS);
    check_value("switch_levels", 32'(switch_levels), 32'(exp_levels));
    finish_test("glitch_reject");

    // Two switches settle together and the lower index must go first
    sw    = random_below(`SW_COUNT);
    other = (sw + 1 + random_below(`SW_COUNT - 1)) % `SW_COUNT;
    apply_changes(one_hot(sw) | one_hot(other), HOLD_CLKS);
    drain_events();
    finish_test("priority");

    // Ack is withheld while the same switch moves twice more
    sw = random_below(`SW_COUNT);
    apply_changes(one_hot(sw), HOLD_CLKS);
    check_value("event_req", 32'(event_req), 32'd1);
    apply_changes(one_hot(sw), HOLD_CLKS);
    apply_changes(one_hot(sw), HOLD_CLKS);
    check_value("event_level", 32'(event_level), 32'(pins[sw]));
    drain_events();
    finish_test("coalesce");

    for (int n = 0; n < RANDOM_CHANGES; n++) begin
      sw = random_below(`SW_COUNT);
      apply_changes(one_hot(sw), HOLD_CLKS + random_below(8));
      // About half the time events pile up before the host reacts
      if (random_below(2) == 0) begin
        drain_events();
      end
    end
    drain_events();
    check_value("switch_levels", 32'(switch_levels), 32'(pins));
    finish_test("random_run");

    print_counts();
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: switch_bank.f
+incdir+.
switch_bank_pkg.sv
io_synchronizer.sv
switch_core.sv
switch_event_queue.sv
switch_bank_top.sv
switch_bank_tb.sv

// File: Makefile
# Verilator build and run for the switch bank testbench

TOP := switch_bank_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f switch_bank.f -o $(TOP)

# The run fails unless the pass message shows up in the output
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
